// ==== hw/bf_pkg.sv ====
package bf_pkg;

	// data memory geometry
	localparam int addr_w = 12;
	localparam int cell_count = 1 << addr_w;
	localparam int data_w = 8;

	localparam int pc_w = 10;

	// one-hot operation word, one bit per command
	localparam int op_w = 8;
	localparam int op_inc = 0;
	localparam int op_dec = 1;
	localparam int op_incdp = 2;
	localparam int op_decdp = 3;
	localparam int op_in = 4;
	localparam int op_out = 5;
	localparam int op_loopbegin = 6;
	localparam int op_loopend = 7;

	// bracket stack, sp carries one extra bit so that full and empty differ
	localparam int loop_depth = 16;
	localparam int sp_w = $clog2(loop_depth);

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;
	typedef logic [pc_w-1:0] pc_t;
	typedef logic [op_w-1:0] op_t;

	typedef enum logic [1:0] {
		issue,
		wait_loop,
		skip,
		halted
	} fetch_state_t;

endpackage

// ==== hw/bf_data_port_if.sv ====
interface bf_data_port_if import bf_pkg::*; ();

	logic read_en;
	addr_t read_addr;
	data_t read_data; // valid one cycle after read_en

	logic write_en;
	addr_t write_addr;
	data_t write_data;

	logic ready; // low while the cells are being cleared

	modport exec (
		output read_en,
		output read_addr,
		input read_data
	);

	modport store (
		output write_en,
		output write_addr,
		output write_data
	);

	modport ram (
		input read_en,
		input read_addr,
		output read_data,
		input write_en,
		input write_addr,
		input write_data,
		output ready
	);

endinterface

// ==== hw/bf_fetch_decode.sv ====
module bf_fetch_decode import bf_pkg::*; (
	input logic clk,
	input logic reset,
	output pc_t prog_addr,
	input data_t prog_data,
	output op_t operation_in,
	output logic ack_in,
	input logic ack,
	input logic loop_done,
	input logic cell_zero,
	output logic halted
);

	fetch_state_t state;
	pc_t pc;
	pc_t loop_stack [loop_depth];
	logic [sp_w:0] sp;
	pc_t top_pc;
	pc_t skip_depth; // nesting level while scanning past a skipped body
	logic running;
	op_t cur_op;
	logic push;
	logic pop;
	logic jump;

	// translate the character under pc, anything else decodes to zero
	always_comb begin
		cur_op = '0;
		case (prog_data)
			"+": cur_op[op_inc] = 1'b1;
			"-": cur_op[op_dec] = 1'b1;
			">": cur_op[op_incdp] = 1'b1;
			"<": cur_op[op_decdp] = 1'b1;
			",": cur_op[op_in] = 1'b1;
			".": cur_op[op_out] = 1'b1;
			"[": cur_op[op_loopbegin] = 1'b1;
			"]": cur_op[op_loopend] = 1'b1;
			default: cur_op = '0;
		endcase
	end

	assign prog_addr = pc;
	assign operation_in = cur_op; // stays put because pc holds until ack
	assign ack_in = running && (state == issue) && (cur_op != '0);
	assign halted = (state == bf_pkg::halted);

	// while waiting for the loop report pc still points at the bracket
	assign push = (state == wait_loop) && loop_done && cur_op[op_loopbegin] && !cell_zero;
	assign pop = (state == wait_loop) && loop_done && cur_op[op_loopend] && cell_zero;
	assign jump = (state == wait_loop) && loop_done && cur_op[op_loopend] && !cell_zero;

	assign top_pc = loop_stack[sp[sp_w-1:0] - 1'b1];

	always_ff @(posedge clk) begin
		if (push)
			loop_stack[sp[sp_w-1:0]] <= pc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= issue;
			pc <= '0;
			sp <= '0;
			skip_depth <= '0;
			running <= 1'b0;
		end else begin
			running <= 1'b1; // first offer comes one cycle after reset
			if (push)
				sp <= sp + 1'b1;
			else if (pop)
				sp <= sp - 1'b1;

			case (state)
				issue: begin
					if (running) begin
						if (prog_data == '0)
							state <= bf_pkg::halted;
						else if (cur_op == '0)
							pc <= pc + 1'b1; // comment character
						else if (ack) begin
							if (cur_op[op_loopbegin] || cur_op[op_loopend])
								state <= wait_loop;
							else
								pc <= pc + 1'b1;
						end
					end
				end
				wait_loop: begin
					if (loop_done) begin
						if (jump) begin
							pc <= top_pc + 1'b1; // back to the first command of the body
							state <= issue;
						end else if (cur_op[op_loopbegin] && cell_zero) begin
							pc <= pc + 1'b1;
							skip_depth <= '0;
							state <= skip;
						end else begin
							pc <= pc + 1'b1;
							state <= issue;
						end
					end
				end
				skip: begin
					if (prog_data == '0) begin
						state <= bf_pkg::halted; // unbalanced program ends here
					end else begin
						pc <= pc + 1'b1;
						if (cur_op[op_loopbegin])
							skip_depth <= skip_depth + 1'b1;
						else if (cur_op[op_loopend]) begin
							if (skip_depth == '0)
								state <= issue; // matching bracket found
							else
								skip_depth <= skip_depth - 1'b1;
						end
					end
				end
				default: state <= bf_pkg::halted;
			endcase
		end
	end

	// the loop report comes from the store stage two cycles after execute took the bracket
	assert property (@(posedge clk) disable iff (reset) push |-> (sp < loop_depth));
	assert property (@(posedge clk) disable iff (reset) (pop || jump) |-> (sp != '0));

endmodule

// ==== hw/bf_execute.sv ====
module bf_execute import bf_pkg::*; (
	input logic clk,
	input logic reset,
	input addr_t dp,
	output logic dp_ce,
	output logic dp_down,
	input op_t operation_in,
	input logic ack_in,
	output logic ack,
	input data_t in_data,
	input logic in_valid,
	output logic in_ack,
	output op_t operation,
	output data_t a,
	output addr_t dp_cache,
	bf_data_port_if.exec mem
);

	logic prefetched; // second cycle of a memory read when read_data is valid
	logic cell_dirty; // a holds a newer cell value than the RAM
	logic need_mem;
	logic need_in;
	logic do_mem_fetch;
	logic do_reg_forward;
	logic datum_ready;
	logic ext_wait;
	logic op_dirties;
	data_t data_input;

	assign need_mem = ack_in && (operation_in[op_inc] || operation_in[op_dec] ||
		operation_in[op_out] || operation_in[op_loopbegin] || operation_in[op_loopend]);
	assign need_in = ack_in && operation_in[op_in];

	// loop operations leave a equal to the cell, so they count as well
	assign op_dirties = operation_in[op_inc] || operation_in[op_dec] || operation_in[op_in] ||
		operation_in[op_loopbegin] || operation_in[op_loopend];

	assign do_mem_fetch = need_mem && !cell_dirty;
	assign do_reg_forward = need_mem && cell_dirty;

	assign mem.read_en = do_mem_fetch;
	assign mem.read_addr = dp;

	assign data_input = do_reg_forward ? a : mem.read_data;
	assign datum_ready = (do_mem_fetch && prefetched) || do_reg_forward;

	// stall on the read cycle and while no input byte is present
	assign ext_wait = (need_in && !in_valid) || (do_mem_fetch && !prefetched);
	assign ack = ack_in && !ext_wait;
	assign in_ack = ack && need_in;

	assign dp_ce = ack && (operation_in[op_incdp] || operation_in[op_decdp]);
	assign dp_down = ack && operation_in[op_decdp];

	always_ff @(posedge clk) begin
		if (reset) begin
			prefetched <= 1'b0;
			cell_dirty <= 1'b0;
			operation <= '0;
		end else begin
			prefetched <= do_mem_fetch && !prefetched;
			if (ack) begin
				operation <= operation_in;
				cell_dirty <= op_dirties;
			end else begin
				operation <= '0; // bubble, store ignores it
			end
		end
	end

	always_ff @(posedge clk) begin
		dp_cache <= dp; // pointer as it was when the operation was taken
		if (ack) begin
			if (datum_ready) begin
				if (operation_in[op_inc])
					a <= data_input + 1'b1;
				else if (operation_in[op_dec])
					a <= data_input - 1'b1;
				else
					a <= data_input;
			end else if (need_in) begin
				a <= in_data;
			end
		end
	end

	// the prefetched cycle still reads the cell that the first cycle asked for
	assert property (@(posedge clk) disable iff (reset)
		prefetched |-> (mem.read_en && (mem.read_addr == $past(mem.read_addr))));
	// a byte taken by in reaches the store stage in the next cycle
	assert property (@(posedge clk) disable iff (reset)
		in_ack |=> (operation[op_in] && (a == $past(in_data))));

endmodule

// ==== hw/bf_store.sv ====
module bf_store import bf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic dp_ce,
	input logic dp_down,
	input op_t operation,
	input data_t a,
	input addr_t dp_cache,
	output addr_t dp,
	output data_t out_data,
	output logic out_valid,
	output logic loop_done,
	output logic cell_zero,
	bf_data_port_if.store mem
);

	logic is_loop;

	assign is_loop = operation[op_loopbegin] || operation[op_loopend];

	// only cell-changing operations write back
	assign mem.write_en = operation[op_inc] || operation[op_dec] || operation[op_in];
	assign mem.write_addr = dp_cache;
	assign mem.write_data = a;

	// operation is zero in a bubble, so this is a single-cycle pulse
	assign out_valid = operation[op_out];
	assign out_data = a;

	always_ff @(posedge clk) begin
		if (reset) begin
			dp <= '0;
			loop_done <= 1'b0;
			cell_zero <= 1'b0;
		end else begin
			if (dp_ce) begin
				// wraps at both ends of the cell array
				if (dp_down)
					dp <= dp - 1'b1;
				else
					dp <= dp + 1'b1;
			end
			loop_done <= is_loop;
			cell_zero <= (a == '0); // fetch looks at it only with loop_done
		end
	end

endmodule

// ==== hw/bf_data_ram.sv ====
module bf_data_ram import bf_pkg::*; (
	input logic clk,
	input logic reset,
	bf_data_port_if.ram mem
);

	data_t cells [cell_count];
	addr_t clear_addr;
	logic clearing;

	assign mem.ready = !clearing;

	// walk every address once after reset, one cell per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			clearing <= 1'b1;
			clear_addr <= '0;
		end else if (clearing) begin
			clear_addr <= clear_addr + 1'b1;
			if (clear_addr == addr_t'(cell_count - 1))
				clearing <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (clearing)
			cells[clear_addr] <= '0;
		else if (mem.write_en)
			cells[mem.write_addr] <= mem.write_data;
	end

	always_ff @(posedge clk) begin
		if (mem.read_en) begin
			if (mem.write_en && (mem.write_addr == mem.read_addr))
				mem.read_data <= mem.write_data; // write-first on collision
			else
				mem.read_data <= cells[mem.read_addr];
		end
	end

endmodule

// ==== hw/bf_core.sv ====
module bf_core import bf_pkg::*; (
	input logic clk,
	input logic reset,
	output pc_t prog_addr,
	input data_t prog_data,
	input data_t in_data,
	input logic in_valid,
	output logic in_ack,
	output data_t out_data,
	output logic out_valid,
	output logic halted
);

	op_t operation_in;
	op_t operation;
	logic ack_in;
	logic ack;
	logic dp_ce;
	logic dp_down;
	addr_t dp;
	addr_t dp_cache;
	data_t a;
	logic loop_done;
	logic cell_zero;
	logic fetch_reset;

	bf_data_port_if dmem ();

	// fetch stays idle until the data RAM has been cleared
	assign fetch_reset = reset || !dmem.ready;

	bf_fetch_decode u_fetch (
		.clk (clk),
		.reset (fetch_reset),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.operation_in (operation_in),
		.ack_in (ack_in),
		.ack (ack),
		.loop_done (loop_done),
		.cell_zero (cell_zero),
		.halted (halted)
	);

	bf_execute u_execute (
		.clk (clk),
		.reset (reset),
		.dp (dp),
		.dp_ce (dp_ce),
		.dp_down (dp_down),
		.operation_in (operation_in),
		.ack_in (ack_in),
		.ack (ack),
		.in_data (in_data),
		.in_valid (in_valid),
		.in_ack (in_ack),
		.operation (operation),
		.a (a),
		.dp_cache (dp_cache),
		.mem (dmem.exec)
	);

	bf_store u_store (
		.clk (clk),
		.reset (reset),
		.dp_ce (dp_ce),
		.dp_down (dp_down),
		.operation (operation),
		.a (a),
		.dp_cache (dp_cache),
		.dp (dp),
		.out_data (out_data),
		.out_valid (out_valid),
		.loop_done (loop_done),
		.cell_zero (cell_zero),
		.mem (dmem.store)
	);

	bf_data_ram u_ram (
		.clk (clk),
		.reset (reset),
		.mem (dmem.ram)
	);

endmodule

// ==== sim/bf_checker.sv ====
module bf_checker import bf_pkg::*; #(
	parameter int stream_len = 16
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic summary_req,
	input int test_id,
	input data_t prog [1 << pc_w],
	input data_t stream [stream_len],
	input data_t in_data,
	input logic in_valid,
	input logic in_ack,
	input data_t out_data,
	input logic out_valid,
	input logic halted,
	output logic timed_out,
	output int error_total
);

	localparam int prog_len = 1 << pc_w;
	localparam int step_cap = 20000;

	data_t tape [cell_count];
	data_t exp_out [$];
	data_t acked [$]; // input bytes the core actually took
	int exp_in_count;
	int model_steps;
	int out_pos;
	int value_errors;
	int protocol_errors;
	int compared;
	longint cycles;
	longint limit;
	logic armed;
	logic done_seen;

	assign error_total = value_errors + protocol_errors;

	initial begin
		timed_out = 1'b0;
		value_errors = 0;
		protocol_errors = 0;
		compared = 0;
		cycles = 0;
		limit = 0;
		armed = 1'b0;
		done_seen = 1'b0;
		out_pos = 0;
		exp_in_count = 0;
	end

	function automatic string test_name(input int id);
		case (id)
			0: return "arith";
			1: return "pointer";
			2: return "input";
			3: return "echo";
			4: return "loops";
			5: return "skip";
			6: return "comments";
			default: return "unknown";
		endcase
	endfunction

	// plain interpreter over the loaded program that fills the expected output queue
	task automatic run_model();
		int pc;
		int depth;
		addr_t mp;
		data_t c;
		exp_out.delete();
		for (int i = 0; i < cell_count; i++)
			tape[i] = '0;
		pc = 0;
		mp = '0;
		model_steps = 0;
		exp_in_count = 0;
		while (pc < prog_len && prog[pc] != 8'h00 && model_steps < step_cap) begin
			c = prog[pc];
			model_steps++;
			case (c)
				"+": tape[mp] = tape[mp] + 8'd1;
				"-": tape[mp] = tape[mp] - 8'd1;
				">": mp = mp + 1'b1;
				"<": mp = mp - 1'b1; // cell 0 wraps to the last cell
				",": begin
					tape[mp] = (exp_in_count < stream_len) ? stream[exp_in_count] : 8'h00;
					exp_in_count++;
				end
				".": exp_out.push_back(tape[mp]);
				"[": begin
					if (tape[mp] == 8'h00) begin
						depth = 1;
						// every skipped character costs the core a cycle too
						while (depth > 0 && pc < prog_len - 1) begin
							pc++;
							model_steps++;
							if (prog[pc] == "[")
								depth++;
							else if (prog[pc] == "]")
								depth--;
						end
					end
				end
				"]": begin
					if (tape[mp] != 8'h00) begin
						depth = 1;
						while (depth > 0 && pc > 0) begin
							pc--;
							if (prog[pc] == "]")
								depth++;
							else if (prog[pc] == "[")
								depth--;
						end
					end
				end
				default: begin
				end
			endcase
			pc++;
		end
	endtask

	always @(posedge clk) begin
		if (start) begin
			run_model();
			acked.delete();
			out_pos = 0;
			done_seen = 1'b0;
			limit = limit + longint'(model_steps) * 6 + 4200 + 100; // RAM clear plus margin
			armed = 1'b1;
		end
		cycles++;
		if (armed && !timed_out && cycles > limit) begin
			$display("timeout: %s did not halt within %0d cycles", test_name(test_id), limit);
			timed_out <= 1'b1;
		end

		if (!reset && !start) begin
			if (in_ack) begin
				if (!in_valid) begin
					protocol_errors++;
					$display("in_ack was raised while in_valid was low in %s", test_name(test_id));
				end else begin
					acked.push_back(in_data);
					if (acked.size() > exp_in_count) begin
						protocol_errors++;
						$display("%s took more input bytes than the program reads",
							test_name(test_id));
					end
				end
			end

			if (out_valid) begin
				if (done_seen || out_pos >= exp_out.size()) begin
					protocol_errors++;
					$display("extra output byte %0d from %s", out_data, test_name(test_id));
				end else if (out_data != exp_out[out_pos]) begin
					value_errors++;
					$display("Fail %s expected %0d actual %0d", test_name(test_id),
						exp_out[out_pos], out_data);
				end
				out_pos++;
				compared++;
			end

			if (halted && !done_seen) begin
				done_seen = 1'b1;
				if (out_pos < exp_out.size()) begin
					protocol_errors++;
					$display("%s halted after %0d of %0d output bytes", test_name(test_id),
						out_pos, exp_out.size());
				end
				if (acked.size() != exp_in_count) begin
					value_errors++;
					$display("Fail %s expected %0d actual %0d", test_name(test_id),
						exp_in_count, acked.size());
				end
			end
		end

		if (summary_req)
			$display("checker: %0d value errors, %0d protocol errors, %0d outputs compared",
				value_errors, protocol_errors, compared);
	end

endmodule

// ==== sim/bf_core_tb.sv ====
module bf_core_tb import bf_pkg::*; ();

	localparam int prog_depth = 1 << pc_w;
	localparam int stream_len = 16;
	localparam int num_programs = 7;

	logic clk;
	logic reset;
	pc_t prog_addr;
	data_t prog_data;
	data_t in_data;
	logic in_valid;
	logic in_ack;
	data_t out_data;
	logic out_valid;
	logic halted;

	data_t prog_mem [prog_depth];
	data_t in_stream [stream_len]; // bytes offered to the core, in order
	int in_gap [stream_len]; // idle cycles before each byte is offered
	int feed_idx;
	int feed_wait;
	int test_id;
	logic start;
	logic summary_req;
	logic timed_out;
	int error_total;

	assign prog_data = prog_mem[prog_addr]; // program memory answers combinationally

	bf_core uut (
		.clk (clk),
		.reset (reset),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.in_data (in_data),
		.in_valid (in_valid),
		.in_ack (in_ack),
		.out_data (out_data),
		.out_valid (out_valid),
		.halted (halted)
	);

	bf_checker #(.stream_len(stream_len)) u_check (
		.clk (clk),
		.reset (reset),
		.start (start),
		.summary_req (summary_req),
		.test_id (test_id),
		.prog (prog_mem),
		.stream (in_stream),
		.in_data (in_data),
		.in_valid (in_valid),
		.in_ack (in_ack),
		.out_data (out_data),
		.out_valid (out_valid),
		.halted (halted),
		.timed_out (timed_out),
		.error_total (error_total)
	);

	always #20 clk = ~clk;

	function automatic string program_text(input int id);
		case (id)
			0: return "+++.--.---.++++.>-.--.";
			1: return "+>++>+++<<.>.>.<<<-.>>>+.";
			2: return ",.,+.,,.";
			3: return ",[.,]";
			4: return "+++[>++++[>+++<-]<-]>>.<<++++++[>++++++++<-]>+.";
			5: return "[+[.-]>.]+.[[-].]>[<+>-[-]]++.";
			6: return "hello +x+ world.\n# ab+.c";
			default: return "";
		endcase
	endfunction

	// load one program, draw its input bytes and gaps, reset the core and wait for halted
	task automatic run_program(input int id);
		string text;
		@(posedge clk);
		#1;
		text = program_text(id);
		for (int i = 0; i < prog_depth; i++) begin
			if (i < text.len())
				prog_mem[i] = text[i];
			else
				prog_mem[i] = '0; // NUL ends the program
		end
		for (int k = 0; k < stream_len; k++) begin
			// the last byte is zero so that echo loops terminate
			in_stream[k] = (k == stream_len - 1) ? 8'h00 : data_t'($urandom_range(255, 1));
			in_gap[k] = int'($urandom_range(5, 0));
		end
		test_id = id;
		reset = 1'b1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		while (!halted && timed_out !== 1'b1)
			@(posedge clk);
		repeat (10) @(posedge clk); // any output after halt shows up here
	endtask

	// the input source offers a byte after its gap and holds it until the core takes it
	always @(posedge clk) begin
		logic was_reset;
		logic took;
		was_reset = reset;
		took = in_ack;
		#1;
		if (was_reset) begin
			feed_idx = 0;
			feed_wait = in_gap[0];
			in_valid = 1'b0;
		end else begin
			if (took) begin
				feed_idx++;
				in_valid = 1'b0;
				feed_wait = in_gap[feed_idx % stream_len];
			end
			if (!in_valid && feed_idx < stream_len) begin
				if (feed_wait == 0) begin
					in_valid = 1'b1;
					in_data = in_stream[feed_idx];
				end else begin
					feed_wait--;
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_data = '0;
		in_valid = 1'b0;
		start = 1'b0;
		summary_req = 1'b0;
		test_id = 0;
		feed_idx = 0;
		feed_wait = 0;
		for (int k = 0; k < stream_len; k++) begin
			in_stream[k] = '0;
			in_gap[k] = 0;
		end
		for (int i = 0; i < prog_depth; i++)
			prog_mem[i] = '0;
		void'($urandom(2));

		for (int p = 0; p < num_programs; p++) begin
			if (timed_out !== 1'b1)
				run_program(p);
		end

		@(posedge clk);
		#1;
		summary_req = 1'b1;
		@(posedge clk);
		#1;
		summary_req = 1'b0;
		if (timed_out === 1'b1 || error_total != 0)
			$display("Simulation FAILED");
		else
			$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== bf_core.f ====
hw/bf_pkg.sv
hw/bf_data_port_if.sv
hw/bf_fetch_decode.sv
hw/bf_execute.sv
hw/bf_store.sv
hw/bf_data_ram.sv
hw/bf_core.sv
sim/bf_checker.sv
sim/bf_core_tb.sv

// ==== run_bf_core.sh ====
#!/usr/bin/env bash
# build the bf_core testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=bf_core_sim
log=bf_core_sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module bf_core_tb \
	-Mdir "$build_dir" -o "$sim_bin" \
	-f bf_core.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "error: verilator build failed with status $build_status"
	exit 1
fi

"./$build_dir/$sim_bin" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "error: simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation PASSED" "$log"; then
	exit 0
fi

echo "error: pass line not found in $log"
exit 1
